// ==== hdl/ex_pkg.sv ====
// Execute stage packet types
`include "ex_defs.svh"

package ex_pkg;
  import isa_pkg::*;

  ////////////////////////////////////////////////////////////
  // Issue side
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`EX_XLEN-1:0]       npc;       // PC plus 4
    logic [31:0]               ir;        // Raw instruction word
    logic [`EX_REG_ADDR_W-1:0] dest_reg;
    logic [`EX_XLEN-1:0]       rega;      // Register file read A
    logic [`EX_XLEN-1:0]       regb;      // Register file read B
    opa_sel_e                  opa_sel;
    opb_sel_e                  opb_sel;
    alu_func_e                 alu_func;
    logic                      cond_branch;
    logic                      uncond_branch;
  } issue_t;

  ////////////////////////////////////////////////////////////
  // Side data and results
  ////////////////////////////////////////////////////////////

  // Travels alongside an op through ALU or multiplier
  typedef struct packed {
    logic [31:0]               ir;
    logic [`EX_XLEN-1:0]       npc;
    logic [`EX_REG_ADDR_W-1:0] dest_reg;
  } op_tag_t;

  typedef struct packed {
    logic                valid;
    op_tag_t             tag;
    logic [`EX_XLEN-1:0] value;
    logic                take_branch;  // Never set for multiplies
  } result_t;

endpackage

// ==== hdl/ex_stage.sv ====
// Execute stage top
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage
  import isa_pkg::*, ex_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    issue_valid,
  input  issue_t  issue,
  output logic    issue_ready,
  output result_t result
);

  logic                alu_valid;
  logic                mult_valid;
  alu_func_e           alu_func;
  logic [`EX_XLEN-1:0] opa;
  logic [`EX_XLEN-1:0] opb;
  logic [`EX_XLEN-1:0] rega;
  logic                cond_branch;
  logic                uncond_branch;
  op_tag_t             tag;
  logic [`EX_XLEN-1:0] alu_value;
  logic                alu_take_branch;
  logic                mult_valid_out;
  logic [`EX_XLEN-1:0] mult_product;
  op_tag_t             mult_tag;
  logic                stage3_valid;

  ////////////////////////////////////////////////////////////
  // Front end
  ////////////////////////////////////////////////////////////

  operand_select u_operand_select (
    .issue_valid   (issue_valid),
    .issue         (issue),
    .stage3_valid  (stage3_valid),
    .issue_ready   (issue_ready),
    .alu_valid     (alu_valid),
    .mult_valid    (mult_valid),
    .alu_func      (alu_func),
    .opa           (opa),
    .opb           (opb),
    .rega          (rega),
    .cond_branch   (cond_branch),
    .uncond_branch (uncond_branch),
    .tag           (tag)
  );

  exec_alu u_exec_alu (
    .opa           (opa),
    .opb           (opb),
    .rega          (rega),
    .alu_func      (alu_func),
    .br_func       (tag.ir[28:26]),  // Condition field of the instruction
    .cond_branch   (cond_branch),
    .uncond_branch (uncond_branch),
    .value         (alu_value),
    .take_branch   (alu_take_branch)
  );

  // opa is the multiplier, opb the multiplicand
  mult_pipe #(.payload_t(op_tag_t)) u_mult_pipe (
    .clock        (clock),
    .reset        (reset),
    .valid_in     (mult_valid),
    .mplier       (opa),
    .mcand        (opb),
    .payload_in   (tag),
    .valid_out    (mult_valid_out),
    .product      (mult_product),
    .payload_out  (mult_tag),
    .stage3_valid (stage3_valid)
  );

  result_merge u_result_merge (
    .clock           (clock),
    .reset           (reset),
    .alu_valid       (alu_valid),
    .alu_value       (alu_value),
    .alu_take_branch (alu_take_branch),
    .alu_tag         (tag),
    .mult_valid      (mult_valid_out),
    .mult_product    (mult_product),
    .mult_tag        (mult_tag),
    .result          (result)
  );

endmodule

// ==== hdl/exec_alu.sv ====
// ALU and branch condition
`timescale 1ns/100ps
`include "ex_defs.svh"

module exec_alu
  import isa_pkg::*;
(
  input  logic [`EX_XLEN-1:0] opa,
  input  logic [`EX_XLEN-1:0] opb,
  input  logic [`EX_XLEN-1:0] rega,
  input  alu_func_e           alu_func,
  input  logic [2:0]          br_func,  // Instruction bits 28:26
  input  logic                cond_branch,
  input  logic                uncond_branch,
  output logic [`EX_XLEN-1:0] value,
  output logic                take_branch
);

  localparam int msb    = `EX_XLEN - 1;
  localparam int shamt_w = $clog2(`EX_XLEN);

  logic [shamt_w-1:0] shamt;
  br_cond_t           br;
  logic               cond;

  // Signs equal means unsigned compare works, else the negative one is less
  function automatic logic signed_lt(input logic [`EX_XLEN-1:0] a,
                                     input logic [`EX_XLEN-1:0] b);
    if (a[msb] == b[msb])
      return a < b;
    else
      return a[msb];
  endfunction

  ////////////////////////////////////////////////////////////
  // Arithmetic and logic
  ////////////////////////////////////////////////////////////

  assign shamt = opb[shamt_w-1:0];  // Low 6 bits only

  always_comb
  begin
    case (alu_func)
      alu_add:    value = opa + opb;
      alu_sub:    value = opa - opb;
      alu_and:    value = opa & opb;
      alu_bic:    value = opa & ~opb;
      alu_bis:    value = opa | opb;
      alu_ornot:  value = opa | ~opb;
      alu_xor:    value = opa ^ opb;
      alu_eqv:    value = opa ^ ~opb;
      alu_srl:    value = opa >> shamt;
      alu_sll:    value = opa << shamt;
      alu_sra:    value = $unsigned($signed(opa) >>> shamt);
      alu_cmpult: value = {{msb{1'b0}}, (opa < opb)};
      alu_cmpeq:  value = {{msb{1'b0}}, (opa == opb)};
      alu_cmpule: value = {{msb{1'b0}}, (opa <= opb)};
      alu_cmplt:  value = {{msb{1'b0}}, signed_lt(opa, opb)};
      alu_cmple:  value = {{msb{1'b0}}, signed_lt(opa, opb) | (opa == opb)};
      default:    value = '0;  // mulq goes to the multiplier
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Branch decision
  ////////////////////////////////////////////////////////////

  assign br = br_func;

  always_comb
  begin
    case (br.kind)
      br_lbc:  cond = ~rega[0];
      br_eq:   cond = (rega == '0);
      br_lt:   cond = rega[msb];                  // Sign bit set
      default: cond = rega[msb] | (rega == '0);   // Less or equal zero
    endcase
  end

  // Unconditional always taken; conditional when the (maybe inverted) test holds
  assign take_branch = uncond_branch | (cond_branch & (cond ^ br.invert));

endmodule

// ==== hdl/isa_pkg.sv ====
// Instruction encoding types
`include "ex_defs.svh"

package isa_pkg;

  // ALU function field from decode
  typedef enum logic [4:0] {
    alu_add    = 5'h00,
    alu_sub    = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,  // A and not B
    alu_bis    = 5'h04,  // A or B
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,  // A xnor B
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_mulq   = 5'h0b,  // Routed to the multiplier
    alu_cmpeq  = 5'h0c,
    alu_cmplt  = 5'h0d,
    alu_cmple  = 5'h0e,
    alu_cmpult = 5'h0f,
    alu_cmpule = 5'h10
  } alu_func_e;

  typedef enum logic [1:0] {opa_rega, opa_mem_disp, opa_npc, opa_not3} opa_sel_e;

  // Code 2'b11 is never issued
  typedef enum logic [1:0] {opb_regb, opb_alu_imm, opb_br_disp} opb_sel_e;

  // Branch condition from instruction bits 28:26
  typedef enum logic [1:0] {br_lbc, br_eq, br_lt, br_le} br_kind_e;

  typedef struct packed {
    logic     invert;  // Bit 28 negates the test
    br_kind_e kind;
  } br_cond_t;

  localparam logic [`EX_XLEN-1:0] not3_value   = ~{{(`EX_XLEN-2){1'b0}}, 2'b11};
  localparam logic [`EX_XLEN-1:0] opb_bad_fill = {(`EX_XLEN/32){32'hbaad_beef}};

endpackage

// ==== hdl/mult_pipe.sv ====
// Pipelined chunked multiplier
`timescale 1ns/100ps
`include "ex_defs.svh"

module mult_pipe #(
  parameter type payload_t = logic
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                valid_in,
  input  logic [`EX_XLEN-1:0] mplier,
  input  logic [`EX_XLEN-1:0] mcand,
  input  payload_t            payload_in,
  output logic                valid_out,
  output logic [`EX_XLEN-1:0] product,    // Low word of the full product
  output payload_t            payload_out,
  output logic                stage3_valid
);

  logic                valid_q   [`EX_MULT_STAGES];
  logic [`EX_XLEN-1:0] prod_q    [`EX_MULT_STAGES];
  payload_t            payload_q [`EX_MULT_STAGES];
  logic [`EX_XLEN-1:0] mplier_q  [`EX_MULT_STAGES-1];  // Last stage needs no shift
  logic [`EX_XLEN-1:0] mcand_q   [`EX_MULT_STAGES-1];

  for (genvar i = 0; i < `EX_MULT_STAGES; i++)
  begin : g_stage
    logic                valid_d;
    logic [`EX_XLEN-1:0] mplier_d;
    logic [`EX_XLEN-1:0] mcand_d;
    logic [`EX_XLEN-1:0] prod_d;
    logic [`EX_XLEN-1:0] chunk_d;  // Low multiplier chunk zero extended
    payload_t            payload_d;

    if (i == 0)
    begin : g_head
      assign valid_d   = valid_in;
      assign mplier_d  = mplier;
      assign mcand_d   = mcand;
      assign prod_d    = '0;  // Empty running sum
      assign payload_d = payload_in;
    end
    else
    begin : g_tail
      assign valid_d   = valid_q[i-1];
      assign mplier_d  = mplier_q[i-1];
      assign mcand_d   = mcand_q[i-1];
      assign prod_d    = prod_q[i-1];
      assign payload_d = payload_q[i-1];
    end

    assign chunk_d = {{(`EX_XLEN-`EX_MULT_CHUNK){1'b0}}, mplier_d[`EX_MULT_CHUNK-1:0]};

    always_ff @(posedge clock)
    begin
      if (reset)
        valid_q[i] <= 1'b0;  // Drops anything in flight
      else
        valid_q[i] <= valid_d;
    end

    // Chunk times shifted multiplicand truncated to the word
    always_ff @(posedge clock)
    begin
      prod_q[i]    <= prod_d + chunk_d * mcand_d;
      payload_q[i] <= payload_d;
    end

    if (i < `EX_MULT_STAGES-1)
    begin : g_shift
      always_ff @(posedge clock)
      begin
        mplier_q[i] <= mplier_d >> `EX_MULT_CHUNK;  // Next chunk to the bottom
        mcand_q[i]  <= mcand_d << `EX_MULT_CHUNK;   // Weight of next chunk
      end
    end
  end

  assign valid_out    = valid_q[`EX_MULT_STAGES-1];
  assign product      = prod_q[`EX_MULT_STAGES-1];
  assign payload_out  = payload_q[`EX_MULT_STAGES-1];
  assign stage3_valid = valid_q[`EX_MULT_STAGES-2];  // Completes next cycle

endmodule

// ==== hdl/operand_select.sv ====
// Operand select and routing
`timescale 1ns/100ps
`include "ex_defs.svh"

module operand_select
  import isa_pkg::*, ex_pkg::*;
(
  input  logic                issue_valid,
  input  issue_t              issue,
  input  logic                stage3_valid,  // Multiplier finishes next cycle
  output logic                issue_ready,
  output logic                alu_valid,
  output logic                mult_valid,
  output alu_func_e           alu_func,
  output logic [`EX_XLEN-1:0] opa,
  output logic [`EX_XLEN-1:0] opb,
  output logic [`EX_XLEN-1:0] rega,
  output logic                cond_branch,
  output logic                uncond_branch,
  output op_tag_t             tag
);

  logic [`EX_XLEN-1:0] mem_disp;
  logic [`EX_XLEN-1:0] br_disp;
  logic [`EX_XLEN-1:0] alu_imm;
  logic                accept;
  logic                is_mulq;

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  assign mem_disp = {{(`EX_XLEN-16){issue.ir[15]}}, issue.ir[15:0]};         // Sign extend 16
  assign br_disp  = {{(`EX_XLEN-23){issue.ir[20]}}, issue.ir[20:0], 2'b00};  // Word offset
  assign alu_imm  = {{(`EX_XLEN-8){1'b0}}, issue.ir[20:13]};                 // Zero extend 8

  // Operand A mux where all four codes are legal
  always_comb
  begin
    case (issue.opa_sel)
      opa_rega:     opa = issue.rega;
      opa_mem_disp: opa = mem_disp;
      opa_npc:      opa = issue.npc;
      default:      opa = not3_value;  // Alignment mask
    endcase
  end

  // Operand B mux
  always_comb
  begin
    case (issue.opb_sel)
      opb_regb:    opb = issue.regb;
      opb_alu_imm: opb = alu_imm;
      opb_br_disp: opb = br_disp;
      default:     opb = opb_bad_fill;  // Marker for an illegal select
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Handshake and routing
  ////////////////////////////////////////////////////////////

  // Hold issue one cycle so an ALU result never meets a multiply completion
  assign issue_ready = ~stage3_valid;
  assign accept      = issue_valid & issue_ready;
  assign is_mulq     = (issue.alu_func == alu_mulq);
  assign alu_valid   = accept & ~is_mulq;
  assign mult_valid  = accept & is_mulq;

  assign alu_func      = issue.alu_func;
  assign rega          = issue.rega;  // Branch test operand
  assign cond_branch   = issue.cond_branch;
  assign uncond_branch = issue.uncond_branch;

  assign tag.ir       = issue.ir;
  assign tag.npc      = issue.npc;
  assign tag.dest_reg = issue.dest_reg;

endmodule

// ==== hdl/result_merge.sv ====
// Result bus merge
`timescale 1ns/100ps
`include "ex_defs.svh"

module result_merge
  import ex_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                alu_valid,
  input  logic [`EX_XLEN-1:0] alu_value,
  input  logic                alu_take_branch,
  input  op_tag_t             alu_tag,
  input  logic                mult_valid,    // Already registered in the pipe
  input  logic [`EX_XLEN-1:0] mult_product,
  input  op_tag_t             mult_tag,
  output result_t             result
);

  logic                alu_valid_q;
  logic [`EX_XLEN-1:0] alu_value_q;
  logic                alu_take_branch_q;
  op_tag_t             alu_tag_q;

  ////////////////////////////////////////////////////////////
  // ALU result register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      alu_valid_q <= 1'b0;
    else
      alu_valid_q <= alu_valid;
  end

  always_ff @(posedge clock)
  begin
    if (alu_valid)  // Hold payload between ops
    begin
      alu_value_q       <= alu_value;
      alu_take_branch_q <= alu_take_branch;
      alu_tag_q         <= alu_tag;
    end
  end

  // Issue stall keeps the two paths apart
  always_comb
  begin
    if (mult_valid)
      result = '{valid: 1'b1, tag: mult_tag, value: mult_product, take_branch: 1'b0};
    else
      result = '{valid: alu_valid_q, tag: alu_tag_q, value: alu_value_q,
                 take_branch: alu_take_branch_q};
  end

endmodule

// ==== include/ex_defs.svh ====
// Execute stage widths
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

`define EX_XLEN        64  // Word width of operands and results
`define EX_REG_ADDR_W  5   // Destination register index

////////////////////////////////////////////////////////////
// Multiplier
////////////////////////////////////////////////////////////

`define EX_MULT_CHUNK  16  // Multiplier bits retired per stage
`define EX_MULT_STAGES 4   // Chunk times stages covers the full word

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module ex_stage_tb \
  -f verilog.f -o ex_stage_sim || { echo "Build failed"; exit 1; }
./obj_dir/ex_stage_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "sim passed" sim.log && echo "Simulation PASSED" || { echo "No result in log"; exit 1; }

// ==== sim/ex_stage_asserts.sv ====
// Execute stage assertions
`timescale 1ns/100ps

module ex_stage_asserts
  import ex_pkg::*;
(
  input logic    clock,
  input logic    reset,
  input logic    issue_ready,
  input logic    alu_valid,       // ALU op accepted this cycle
  input logic    mult_valid,      // Multiply accepted this cycle
  input logic    mult_valid_out,
  input result_t result
);

  logic [2:0] mul_age;    // One bit per cycle a multiply has spent in the pipe
  logic       alu_due;    // Registered ALU result on the bus
  logic [2:0] in_flight;  // Accepted since reset and not yet on the bus
  logic       stall_err   = 1'b0;
  logic       collide_err = 1'b0;
  logic       reset_err   = 1'b0;
  logic       early_err   = 1'b0;
  logic       failed_any;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mul_age   <= '0;
      alu_due   <= 1'b0;
      in_flight <= '0;  // In-flight work is dropped
    end
    else
    begin
      mul_age   <= {mul_age[1:0], mult_valid};
      alu_due   <= alu_valid;
      in_flight <= in_flight + 3'(alu_valid | mult_valid) - 3'(result.valid);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stall and collision
  ////////////////////////////////////////////////////////////

  a_stall: assert property (@(posedge clock) disable iff (reset)
                            issue_ready == !mul_age[2])
  else
  begin
    stall_err = 1'b1;
    $error("issue_ready does not match a multiply leaving stage three");
  end

  a_collide: assert property (@(posedge clock) disable iff (reset)
                              !(alu_due && mult_valid_out))
  else
  begin
    collide_err = 1'b1;
    $error("ALU and multiplier results completed in the same cycle");
  end

  ////////////////////////////////////////////////////////////
  // Reset
  ////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge clock) $fell(reset) |-> !result.valid && issue_ready)
  else
  begin
    reset_err = 1'b1;
    $error("Result valid or issue stalled right after reset");
  end

  // Nothing from before reset may reach the bus
  a_early: assert property (@(posedge clock) disable iff (reset)
                            result.valid |-> in_flight != '0)
  else
  begin
    early_err = 1'b1;
    $error("Result appeared without an accepted instruction");
  end

  assign failed_any = stall_err | collide_err | reset_err | early_err;

endmodule

// ==== sim/ex_stage_tb.sv ====
// Execute stage testbench
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage_tb
  import isa_pkg::*, ex_pkg::*;
();

  localparam int half_period = 20;
  localparam int num_ops     = 400;
  localparam int max_cycles  = num_ops * 5 + 100;  // Stalls, idle slots, resets, drain

  logic    clock;
  logic    reset;
  logic    issue_valid;
  issue_t  issue;
  logic    issue_ready;
  result_t result;

  integer  seed;
  int      cycle;
  result_t expected [8];  // Ring of due results indexed by cycle

  ex_stage DUT (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready),
    .result      (result)
  );

  bind ex_stage ex_stage_asserts u_ex_stage_asserts (
    .clock          (clock),
    .reset          (reset),
    .issue_ready    (issue_ready),
    .alu_valid      (alu_valid),
    .mult_valid     (mult_valid),
    .mult_valid_out (mult_valid_out),
    .result         (result)
  );

  initial
  begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  initial
  begin
    #(2 * half_period * max_cycles);
    $display("Watchdog expired before all operations completed");
    end_with_failure();
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [63:0] operand_a_of(input issue_t ins);
    case (ins.opa_sel)
      opa_rega:     return ins.rega;
      opa_mem_disp: return 64'($signed(ins.ir[15:0]));  // 16 bit displacement
      opa_npc:      return ins.npc;
      default:      return ~64'd3;
    endcase
  endfunction

  function automatic logic [63:0] operand_b_of(input issue_t ins);
    case (ins.opb_sel)
      opb_regb:    return ins.regb;
      opb_alu_imm: return 64'(ins.ir[20:13]);
      default:     return 64'($signed(ins.ir[20:0])) * 64'd4;  // Words to bytes
    endcase
  endfunction

  function automatic logic [63:0] alu_result(input alu_func_e f, input logic [63:0] a,
                                             input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = a;
    sb = b;
    case (f)
      alu_add:    return a + b;
      alu_sub:    return a - b;
      alu_and:    return a & b;
      alu_bic:    return a & ~b;
      alu_bis:    return a | b;
      alu_ornot:  return a | ~b;
      alu_xor:    return a ^ b;
      alu_eqv:    return ~(a ^ b);
      alu_srl:    return a >> b[5:0];
      alu_sll:    return a << b[5:0];
      alu_sra:    return sa >>> b[5:0];
      alu_cmpult: return 64'(a < b);
      alu_cmpeq:  return 64'(a == b);
      alu_cmpule: return 64'(a <= b);
      alu_cmplt:  return 64'(sa < sb);
      alu_cmple:  return 64'(sa <= sb);
      default:    return a * b;  // Low word of the product
    endcase
  endfunction

  function automatic logic branch_taken(input issue_t ins);
    logic hit;
    case (ins.ir[27:26])
      2'd0:    hit = !ins.rega[0];
      2'd1:    hit = (ins.rega == '0);
      2'd2:    hit = ($signed(ins.rega) < 64'sd0);
      default: hit = ($signed(ins.rega) <= 64'sd0);
    endcase
    if (ins.ir[28])
      hit = !hit;  // Inverted sense
    return ins.uncond_branch | (ins.cond_branch & hit);
  endfunction

  function automatic result_t expect_of(input issue_t ins);
    result_t r;
    r.valid        = 1'b1;
    r.tag.ir       = ins.ir;
    r.tag.npc      = ins.npc;
    r.tag.dest_reg = ins.dest_reg;
    r.value        = alu_result(ins.alu_func, operand_a_of(ins), operand_b_of(ins));
    r.take_branch  = (ins.alu_func == alu_mulq) ? 1'b0 : branch_taken(ins);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  function automatic issue_t random_issue();
    issue_t ins;
    int     kind;
    ins.npc      = {$random(seed), $random(seed)};
    ins.ir       = $random(seed);
    ins.dest_reg = 5'($random(seed));
    ins.rega     = {$random(seed), $random(seed)};
    ins.regb     = {$random(seed), $random(seed)};
    if (($random(seed) & 7) == 0)
      ins.rega = '0;  // Hits the equal zero tests
    ins.opa_sel  = opa_sel_e'(2'($random(seed)));
    ins.opb_sel  = opb_sel_e'(2'($unsigned($random(seed)) % 3));  // Never the bad code
    ins.alu_func = alu_func_e'(5'($unsigned($random(seed)) % 17));
    if (($random(seed) & 3) == 0)
      ins.alu_func = alu_mulq;  // Extra multiplies so they overlap
    kind = $unsigned($random(seed)) % 3;
    ins.cond_branch   = (kind == 1);
    ins.uncond_branch = (kind == 2);
    return ins;
  endfunction

  task automatic end_with_failure();
    $display("sim failed");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
    $display("FAILED %s got %h expected %h at cycle %0d", name, got, want, cycle);
    end_with_failure();
  endtask

  task automatic check_result();
    logic [2:0] slot;
    result_t    want;
    slot = 3'(cycle);
    want = expected[slot];
    expected[slot] = '0;  // Slot free for reuse
    assert (result.valid == want.valid)
    else report_mismatch("result.valid", 128'(result.valid), 128'(want.valid));
    if (want.valid)
    begin
      assert (result.value == want.value)
      else report_mismatch("result.value", 128'(result.value), 128'(want.value));
      assert (result.tag == want.tag)
      else report_mismatch("result.tag", 128'(result.tag), 128'(want.tag));
      assert (result.take_branch == want.take_branch)
      else report_mismatch("result.take_branch", 128'(result.take_branch),
                           128'(want.take_branch));
    end
  endtask

  // Check the bus and drive the next inputs on the falling edge
  task automatic step(input logic valid, input issue_t ins, output logic took);
    logic [2:0] slot;
    @(negedge clock);
    cycle++;
    check_result();
    if (DUT.u_ex_stage_asserts.failed_any)
    begin
      $display("A bound assertion on the execute stage fired");
      end_with_failure();
    end
    issue_valid = valid;
    issue       = ins;
    took        = valid & issue_ready;  // Ready comes from registers only
    if (took)
    begin
      slot = 3'(cycle + ((ins.alu_func == alu_mulq) ? 4 : 1));
      expected[slot] = expect_of(ins);
    end
  endtask

  task automatic clear_expected();
    for (int i = 0; i < 8; i++)
      expected[i] = '0;
  endtask

  // Reset must drop a multiply already in the pipe
  task automatic reset_in_flight();
    issue_t ins;
    logic   took;
    ins = random_issue();
    ins.alu_func = alu_mulq;
    took = 1'b0;
    while (!took)
      step(1'b1, ins, took);
    step(1'b0, ins, took);
    reset = 1'b1;
    clear_expected();
    repeat (3) step(1'b0, ins, took);
    reset = 1'b0;
    repeat (6) step(1'b0, ins, took);  // Bus must stay quiet
  endtask

  initial
  begin
    issue_t ins;
    logic   took;
    int     accepted;
    logic   mid_reset_done;
    seed           = 32'h7835_04c9;
    reset          = 1'b1;
    issue_valid    = 1'b0;
    issue          = '0;
    cycle          = 0;
    accepted       = 0;
    mid_reset_done = 1'b0;
    clear_expected();
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    ins = random_issue();
    while (accepted < num_ops)
    begin
      if (accepted == num_ops / 2 && !mid_reset_done)
      begin
        reset_in_flight();
        mid_reset_done = 1'b1;
      end
      step(($random(seed) & 3) != 0, ins, took);  // About one idle slot in four
      if (took)
      begin
        accepted++;
        ins = random_issue();  // Held while stalled
      end
    end
    repeat (6) step(1'b0, ins, took);  // Drain the multiplier
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/ex_pkg.sv
hdl/operand_select.sv
hdl/exec_alu.sv
hdl/mult_pipe.sv
hdl/result_merge.sv
hdl/ex_stage.sv
sim/ex_stage_asserts.sv
sim/ex_stage_tb.sv
